//--- Makefile
SIM = obj_dir/vecAluSim

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --timescale 1ns/10ps --top-module vecAluTb \
		-f build.f -o vecAluSim

# Pass only when the testbench prints the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

//--- build.f
verilog/vecAluPkg.sv
verilog/fpAlu.sv
verilog/vecLanes.sv
verilog/vecPermute.sv
verilog/resultSelect.sv
verilog/vecAluTop.sv
sim/clockGen.sv
sim/vecAluTb.sv

//--- sim/clockGen.sv
`default_nettype none
`timescale 1ns/10ps

module clockGen #(
    parameter int Period      = 4,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;      // Released just after an edge
    end

endmodule

`default_nettype wire

//--- sim/vecAluTb.sv
`default_nettype none
`timescale 1ns/10ps

module vecAluTb;
    import vecAluPkg::*;

    localparam int Depth = PipeDepth;

    typedef struct packed {
        vecReq           req;
        fpWord           expS;      // Expected rout
        fpVec            expV;      // Expected vout
        logic [8*20-1:0] name;
    } testCase;

    logic        clk;
    logic        rst_n;
    logic        en;
    vecReq       req;
    logic        resValid;
    fpWord       rout;
    fpVec        vout;

    testCase     tests[$];
    int          pending[$];        // Accepted requests, oldest first
    int          nextIdx;
    int          reqIdx;            // Test now on req
    int          cycles;
    int          cycleLimit;
    logic [31:0] lfsr;

    clockGen #(.Period(4), .ResetCycles(8)) clockGen_inst (.clk(clk), .rst_n(rst_n));

    vecAluTop #(.Depth(Depth)) vecAluTop_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .req      (req),
        .resValid (resValid),
        .rout     (rout),
        .vout     (vout)
    );

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic checkScalar(input string name, input fpWord expected, input fpWord actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s rout expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkVector(input string name, input fpVec expected, input fpVec actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s vout expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic loadTests();
        int              fd;
        int              n;
        string           line;
        logic [7:0]      op;
        logic [7:0]      imm;
        logic [127:0]    v1;
        logic [127:0]    v2;
        logic [31:0]     r1;
        logic [31:0]     r2;
        logic [31:0]     expS;
        logic [127:0]    expV;
        logic [8*20-1:0] name;
        testCase         tc;
        fd = $fopen("sim/vecAluTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/vecAluTests.txt");
            $display("Test failed");
            $fatal(1);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %s",
                                op, imm, v1, v2, r1, r2, expS, expV, name);
                    if (n != 9) begin
                        $display("Malformed line in the test file: %s", line);
                        $display("Test failed");
                        $fatal(1);
                    end else begin
                        tc.req  = '{valid: 1'b1, op: vecOp'(op[4:0]), imm: imm,
                                    v1: v1, v2: v2, r1: r1, r2: r2};
                        tc.expS = expS;
                        tc.expV = expV;
                        tc.name = name;
                        tests.push_back(tc);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        en      <= 1'b0;
        req     <= '0;
        nextIdx <= 0;
        reqIdx  <= 0;
        cycles  = 0;
        lfsr    = 32'ha1e9_8b5e;
        loadTests();
        cycleLimit = 4 * (tests.size() + Depth);
    end

    // A request stays on req until an enabled edge takes it
    always @(posedge clk) begin : drive
        logic b0;
        logic b1;
        if (rst_n) begin
            lfsr = nextLfsr(lfsr);
            b0   = lfsr[0];
            lfsr = nextLfsr(lfsr);
            b1   = lfsr[0];
            en   <= b0 | b1;            // Low about one cycle in four
            if (en || !req.valid) begin
                if (nextIdx < tests.size()) begin
                    req     <= tests[nextIdx].req;
                    reqIdx  <= nextIdx;
                    nextIdx <= nextIdx + 1;
                end else begin
                    req <= '0;
                end
            end
        end
    end

    // Outputs and en are stable at the falling edge
    always @(negedge clk) begin : check
        testCase want;
        string   name;
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > cycleLimit) begin
                $display("Timeout after %0d cycles with %0d results still outstanding",
                         cycles, pending.size());
                $display("Test failed");
                $fatal(1);
            end else begin
                if (en && resValid) begin
                    if (pending.size() == 0) begin
                        $display("A result arrived with no request outstanding");
                        $display("Test failed");
                        $fatal(1);
                    end else begin
                        want = tests[pending.pop_front()];
                        name = $sformatf("%0s", want.name);
                        checkScalar(name, want.expS, rout);
                        checkVector(name, want.expV, vout);
                    end
                end
                if (en && req.valid) begin
                    pending.push_back(reqIdx);
                end
                if (nextIdx == tests.size() && !req.valid && pending.size() == 0) begin
                    $display("Test passed");
                    $finish;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/vecAluTests.txt
# op imm v1 v2 r1 r2 expRout expVout name; all hex, vectors list element 3 first
# Expected values use truncation, flush to zero and saturation
00 00 00000000000000000000000000000000 00000000000000000000000000000000 3F800000 40000000 40400000 00000000000000000000000000000000 faddPos
00 00 00000000000000000000000000000000 00000000000000000000000000000000 40A00000 C0000000 40400000 00000000000000000000000000000000 faddMixed
00 00 00000000000000000000000000000000 00000000000000000000000000000000 BF800000 3F000000 BF000000 00000000000000000000000000000000 faddNegBig
00 00 00000000000000000000000000000000 00000000000000000000000000000000 3F800000 33800000 3F800000 00000000000000000000000000000000 faddTrunc
01 00 00000000000000000000000000000000 00000000000000000000000000000000 40000000 40A00000 C0400000 00000000000000000000000000000000 fsubNeg
01 00 00000000000000000000000000000000 00000000000000000000000000000000 3F800000 3F800000 00000000 00000000000000000000000000000000 fsubZero
01 00 00000000000000000000000000000000 00000000000000000000000000000000 C0000000 C0400000 3F800000 00000000000000000000000000000000 fsubMixed
02 00 00000000000000000000000000000000 00000000000000000000000000000000 3FC00000 3FC00000 40100000 00000000000000000000000000000000 fmultNorm
02 00 00000000000000000000000000000000 00000000000000000000000000000000 C0000000 40400000 C0C00000 00000000000000000000000000000000 fmultSign
02 00 00000000000000000000000000000000 00000000000000000000000000000000 40400000 3EAAAAAB 3F800000 00000000000000000000000000000000 fmultTrunc
02 00 00000000000000000000000000000000 00000000000000000000000000000000 71800000 71800000 7F7FFFFF 00000000000000000000000000000000 fmultSat
02 00 00000000000000000000000000000000 00000000000000000000000000000000 0D800000 0D800000 00000000 00000000000000000000000000000000 fmultFlush
03 00 4080000040400000400000003F800000 408000003F800000C00000003F000000 00000000 00000000 00000000 4100000040800000000000003FC00000 vaddMixed
04 00 4080000040400000400000003F800000 C08000003F8000004000000040000000 00000000 00000000 00000000 410000004000000000000000BF800000 vsubMixed
05 00 4080000040400000400000003F800000 408000003F000000C04000003FC00000 00000000 00000000 00000000 418000003FC00000C0C000003FC00000 vmultMixed
0B 00 4080000040400000400000003F800000 00000000000000000000000000000000 3F000000 40000000 00000000 4090000040600000402000003FC00000 vsaddHalf
0C 00 4080000040400000400000003F800000 00000000000000000000000000000000 40000000 00000000 00000000 400000003F80000000000000BF800000 vssubTwo
0D 00 4080000040400000400000003F800000 00000000000000000000000000000000 BF000000 00000000 00000000 C0000000BFC00000BF800000BF000000 vsmultNeg
06 00 4080000040400000400000003F800000 3F800000400000004040000040800000 00000000 00000000 41A00000 00000000000000000000000000000000 vdotPos
06 00 4080000040400000400000003F800000 3E800000C00000003F000000BF800000 00000000 00000000 C0A00000 00000000000000000000000000000000 vdotMixed
08 00 4080000040400000400000003F800000 4080000040400000400000003F800000 00000000 00000000 41200000 00000000000000000000000000000000 vreducePos
08 00 C000000041000000BF0000003FC00000 00000000000000000000000000000000 00000000 00000000 40E00000 00000000000000000000000000000000 vreduceMixed
07 02 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 40400000 00000000000000000000000000000000 vindxTwo
07 FC 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 3F800000 00000000000000000000000000000000 vindxHighBits
07 03 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 40800000 00000000000000000000000000000000 vindxThree
0A 1B 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 00000000 3F800000400000004040000040800000 vswizReverse
0A AA 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 00000000 40400000404000004040000040400000 vswizBroadcast
0A E4 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 00000000 4080000040400000400000003F800000 vswizIdentity
0A 4E 4080000040400000400000003F800000 00000000000000000000000000000000 00000000 00000000 00000000 400000003F8000004080000040400000 vswizRotate
09 00 4080000040400000400000003F800000 00000000000000000000000000000000 C0400000 00000000 00000000 C0400000C0400000C0400000C0400000 vsplatNeg
09 1B 4080000040400000400000003F800000 00000000000000000000000000000000 3F000000 40000000 00000000 3F0000003F0000003F0000003F000000 vsplatHalf
0E 00 0000000040400000C00000003F800000 BF00000040800000C0000000BF800000 41200000 41A00000 00000000 4120000041A0000041A0000041200000 vcompselMixed
0F 00 0000000040400000C00000003F800000 BF00000040800000C0000000BF800000 00000000 00000000 00000000 0000000040800000C00000003F800000 vmaxMixed
10 00 0000000040400000C00000003F800000 BF00000040800000C0000000BF800000 00000000 00000000 00000000 BF00000040400000C0000000BF800000 vminMixed
0F 00 40A0000040000000BF800000C0400000 C0A0000040000000BF800000C0000000 00000000 00000000 00000000 40A0000040000000BF800000C0000000 vmaxEqual
10 00 40A0000040000000BF800000C0400000 C0A0000040000000BF800000C0000000 00000000 00000000 00000000 C0A0000040000000BF800000C0400000 vminEqual
0E 00 40A0000040000000BF800000C0400000 C0A0000040000000BF800000C0000000 3F800000 BF800000 00000000 3F800000BF800000BF800000BF800000 vcompselEqual

//--- verilog/fpAlu.sv
`default_nettype none
`timescale 1ns/10ps

module fpAlu (
    input  vecAluPkg::fpWord a,
    input  vecAluPkg::fpWord b,
    input  vecAluPkg::fpOp   op,
    output vecAluPkg::fpWord result,
    output logic             gt
);
    import vecAluPkg::*;

    logic        signA;
    logic        signB;         // Effective sign of b for add and subtract
    logic [30:0] aMag;
    logic [30:0] bMag;
    logic [23:0] manA;
    logic [23:0] manB;
    logic        greater;
    fpWord       addRes;
    fpWord       mulRes;

    function automatic fpWord packWord(input logic sign, input int e, input logic [22:0] frac);
        if (e <= 0) begin
            return '0;                              // Underflow flushes to zero
        end else if (e >= 255) begin
            return {sign, 8'hFE, 23'h7F_FFFF};      // Largest finite value
        end
        return {sign, 8'(e), frac};
    endfunction

    // Subnormals read as zero
    assign aMag  = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
    assign bMag  = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
    assign manA  = (aMag == 31'd0) ? 24'd0 : {1'b1, a[22:0]};
    assign manB  = (bMag == 31'd0) ? 24'd0 : {1'b1, b[22:0]};
    assign signA = a[31];
    assign signB = b[31] ^ (op == FpSub);

    always_comb begin : addPath
        logic        swap;
        logic        sticky;
        logic        sBig;
        logic        sSmall;
        logic [7:0]  eBig;
        logic [7:0]  diff;
        logic [26:0] mBig;      // Mantissa with guard, round and sticky bits
        logic [26:0] mSmall;
        logic [26:0] aligned;
        logic [26:0] norm;
        logic [27:0] sum;
        logic [4:0]  lz;
        swap   = bMag > aMag;
        mBig   = swap ? {manB, 3'b0} : {manA, 3'b0};
        mSmall = swap ? {manA, 3'b0} : {manB, 3'b0};
        eBig   = swap ? b[30:23] : a[30:23];
        diff   = swap ? (b[30:23] - a[30:23]) : (a[30:23] - b[30:23]);
        sBig   = swap ? signB : signA;
        sSmall = swap ? signA : signB;
        if (diff > 8'd26) begin
            aligned = '0;
            sticky  = |mSmall;
        end else begin
            aligned = mSmall >> diff;
            sticky  = |(mSmall & ((27'd1 << diff) - 27'd1));
        end
        aligned[0] = aligned[0] | sticky;
        if (sBig == sSmall) begin
            sum = {1'b0, mBig} + {1'b0, aligned};
        end else begin
            sum = {1'b0, mBig} - {1'b0, aligned};   // Big operand has the larger magnitude
        end
        lz = 5'd0;
        for (int k = 0; k < 27; k++) begin
            if (sum[k]) begin
                lz = 5'(26 - k);
            end
        end
        norm = sum[26:0] << lz;
        if (sum == 28'd0) begin
            addRes = '0;
        end else if (sum[27]) begin
            addRes = packWord(sBig, int'(eBig) + 1, sum[26:4]);     // Carry out
        end else begin
            addRes = packWord(sBig, int'(eBig) - int'(lz), norm[25:3]);
        end
    end

    always_comb begin : mulPath
        logic [47:0] prod;
        prod = manA * manB;
        if (manA == 24'd0 || manB == 24'd0) begin
            mulRes = '0;
        end else if (prod[47]) begin
            mulRes = packWord(a[31] ^ b[31], int'(a[30:23]) + int'(b[30:23]) - 126,
                              prod[46:24]);
        end else begin
            mulRes = packWord(a[31] ^ b[31], int'(a[30:23]) + int'(b[30:23]) - 127,
                              prod[45:23]);
        end
    end

    // Sign first, then magnitude; both zero compares equal
    always_comb begin
        if (aMag == 31'd0 && bMag == 31'd0) begin
            greater = 1'b0;
        end else if (a[31] != b[31]) begin
            greater = !a[31];
        end else if (a[31]) begin
            greater = aMag < bMag;
        end else begin
            greater = aMag > bMag;
        end
    end

    always_comb begin
        case (op)
            FpAdd, FpSub: result = addRes;
            FpMul:        result = mulRes;
            default:      result = b;      // Compare passes b through
        endcase
    end

    assign gt = (op == FpCmp) && greater;

endmodule

`default_nettype wire

//--- verilog/resultSelect.sv
`default_nettype none
`timescale 1ns/10ps

module resultSelect (
    input  vecAluPkg::laneResult lanes,
    input  vecAluPkg::permResult perm,
    output logic                 resValid,
    output vecAluPkg::fpWord     rout,
    output vecAluPkg::fpVec      vout
);
    import vecAluPkg::*;

    always_comb begin
        rout = '0;
        vout = '0;
        case (perm.op)
            Fadd, Fsub, Fmult: begin
                rout = lanes.lane[0];
            end
            Vdot, Vreduce: begin
                rout = lanes.sum;
            end
            Vindx: begin
                rout = perm.indexed;
            end
            Vadd, Vsub, Vmult, Vsadd, Vssub, Vsmult: begin
                vout = lanes.lane;
            end
            Vsplat, Vswizzle: begin
                vout = perm.vector;
            end
            Vcompsel: begin
                for (int i = 0; i < 4; i++) begin
                    vout[i] = lanes.gt[i] ? perm.r1 : perm.r2;
                end
            end
            // Compare lanes carry v2 through as their result
            Vmax: begin
                for (int i = 0; i < 4; i++) begin
                    vout[i] = lanes.gt[i] ? perm.v1[i] : lanes.lane[i];
                end
            end
            Vmin: begin
                for (int i = 0; i < 4; i++) begin
                    vout[i] = lanes.gt[i] ? lanes.lane[i] : perm.v1[i];
                end
            end
            default: ;
        endcase
    end

    assign resValid = perm.valid;

endmodule

`default_nettype wire

//--- verilog/vecAluPkg.sv
`default_nettype none

package vecAluPkg;

    // IEEE single-precision bit pattern
    typedef logic [31:0] fpWord;

    // Four elements, element 0 in the low bits
    typedef fpWord [3:0] fpVec;

    typedef enum logic [4:0] {
        Fadd,       // Scalar r1 + r2
        Fsub,
        Fmult,
        Vadd,       // Element-wise
        Vsub,
        Vmult,
        Vdot,       // Sum of element products
        Vindx,      // Pick one v1 element by imm
        Vreduce,    // Sum of all v1 elements
        Vsplat,
        Vswizzle,
        Vsadd,      // v1[i] op r1
        Vssub,
        Vsmult,
        Vcompsel,   // r1 where v1[i] > v2[i], else r2
        Vmax,
        Vmin
    } vecOp;

    typedef enum logic [1:0] {
        FpAdd,
        FpSub,
        FpMul,
        FpCmp
    } fpOp;

    typedef struct packed {
        logic       valid;
        vecOp       op;
        logic [7:0] imm;
        fpVec       v1;
        fpVec       v2;
        fpWord      r1;
        fpWord      r2;
    } vecReq;

    typedef struct packed {
        fpVec       lane;
        logic [3:0] gt;     // One compare flag per lane
        fpWord      sum;    // Reduction tree output
    } laneResult;

    typedef struct packed {
        logic  valid;
        vecOp  op;
        fpVec  v1;
        fpWord r1;
        fpWord r2;
        fpWord indexed;
        fpVec  vector;      // Swizzle or splat
    } permResult;

    // Enabled clocks from request to result
    localparam int PipeDepth = 8;

endpackage

`default_nettype wire

//--- verilog/vecAluTop.sv
`default_nettype none
`timescale 1ns/10ps

module vecAluTop #(
    parameter int Depth = vecAluPkg::PipeDepth     // At least 6 for the reduction tree
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  vecAluPkg::vecReq req,
    output logic             resValid,
    output vecAluPkg::fpWord rout,
    output vecAluPkg::fpVec  vout
);
    import vecAluPkg::*;

    laneResult laneRes;
    permResult permRes;

    vecLanes #(.Depth(Depth)) vecLanes_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .res   (laneRes)
    );

    vecPermute #(.Depth(Depth)) vecPermute_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .req   (req),
        .res   (permRes)
    );

    resultSelect resultSelect_inst (
        .lanes    (laneRes),
        .perm     (permRes),
        .resValid (resValid),
        .rout     (rout),
        .vout     (vout)
    );

endmodule

`default_nettype wire

//--- verilog/vecLanes.sv
`default_nettype none
`timescale 1ns/10ps

module vecLanes #(
    parameter int Depth = vecAluPkg::PipeDepth
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  vecAluPkg::vecReq     req,
    output vecAluPkg::laneResult res
);
    import vecAluPkg::*;

    fpWord      opA [4];
    fpWord      opB [4];
    fpOp        laneOp;
    fpVec       laneOut;
    logic [3:0] laneGt;
    fpVec       laneP [0:Depth];
    logic [3:0] gtP [0:Depth];
    fpWord      partLo [0:2];       // Tree level 1, lanes 0+1
    fpWord      partHi [0:2];       // Tree level 1, lanes 2+3
    fpWord      sumP [0:Depth-4];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            opA[i] = req.v1[i];
            opB[i] = req.v2[i];
        end
        case (req.op)
            Fadd, Fsub, Fmult: begin
                opA[0] = req.r1;
                opB[0] = req.r2;
            end
            Vsadd, Vssub, Vsmult: begin
                for (int i = 0; i < 4; i++) begin
                    opB[i] = req.r1;
                end
            end
            Vreduce: begin
                for (int i = 0; i < 4; i++) begin
                    opB[i] = '0;    // Lanes pass v1 into the tree
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        case (req.op)
            Fsub, Vsub, Vssub:          laneOp = FpSub;
            Fmult, Vmult, Vdot, Vsmult: laneOp = FpMul;
            Vcompsel, Vmax, Vmin:       laneOp = FpCmp;
            default:                    laneOp = FpAdd;
        endcase
    end

    for (genvar i = 0; i < 4; i++) begin : lane
        fpAlu laneAlu (.a(opA[i]), .b(opB[i]), .op(laneOp), .result(laneOut[i]), .gt(laneGt[i]));
    end

    assign laneP[0] = laneOut;
    assign gtP[0]   = laneGt;

    for (genvar s = 1; s <= Depth; s++) begin : lanePipe
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                laneP[s] <= '0;
                gtP[s]   <= '0;
            end else if (en) begin
                laneP[s] <= laneP[s-1];
                gtP[s]   <= gtP[s-1];
            end
        end
    end

    fpAlu treeLo (.a(laneP[2][0]), .b(laneP[2][1]), .op(FpAdd), .result(partLo[0]), .gt());
    fpAlu treeHi (.a(laneP[2][2]), .b(laneP[2][3]), .op(FpAdd), .result(partHi[0]), .gt());

    for (genvar s = 1; s <= 2; s++) begin : partPipe
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                partLo[s] <= '0;
                partHi[s] <= '0;
            end else if (en) begin
                partLo[s] <= partLo[s-1];
                partHi[s] <= partHi[s-1];
            end
        end
    end

    fpAlu treeTop (.a(partLo[2]), .b(partHi[2]), .op(FpAdd), .result(sumP[0]), .gt());

    // Two stages after the last adder, then padding out to Depth
    for (genvar s = 1; s <= Depth - 4; s++) begin : sumPipe
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sumP[s] <= '0;
            end else if (en) begin
                sumP[s] <= sumP[s-1];
            end
        end
    end

    assign res = '{lane: laneP[Depth], gt: gtP[Depth], sum: sumP[Depth-4]};

endmodule

`default_nettype wire

//--- verilog/vecPermute.sv
`default_nettype none
`timescale 1ns/10ps

module vecPermute #(
    parameter int Depth = vecAluPkg::PipeDepth
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  vecAluPkg::vecReq     req,
    output vecAluPkg::permResult res
);
    import vecAluPkg::*;

    fpWord     indexed;
    fpVec      swizzle;
    fpVec      vector;
    permResult stage [0:Depth];

    always_comb begin
        indexed = req.v1[req.imm[1:0]];
        for (int k = 0; k < 4; k++) begin
            swizzle[k] = req.v1[req.imm[2*k +: 2]];     // Two imm bits per element
        end
        vector = (req.op == Vsplat) ? {4{req.r1}} : swizzle;
    end

    assign stage[0] = '{valid: req.valid, op: req.op, v1: req.v1, r1: req.r1, r2: req.r2,
                        indexed: indexed, vector: vector};

    for (genvar s = 1; s <= Depth; s++) begin : permPipe
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stage[s] <= '0;
            end else if (en) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    assign res = stage[Depth];

endmodule

`default_nettype wire
